// File: logic/stq_macros.svh
`ifndef STQ_MACROS_SVH
`define STQ_MACROS_SVH

// ======================================================================
// Store queue sizing
// ======================================================================

// Number of queue entries, power of two
`define STQ_DEPTH 8

// Physical address width
`define STQ_ADDR_W 32

`define STQ_DATA_W 64  // Cache data width, one double word

`endif

// File: logic/mem_pkg.sv
`include "stq_macros.svh"

package mem_pkg;

  // Access size of a load or store
  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } size_e;

  // Write request to the data cache
  typedef struct packed {
    logic [`STQ_ADDR_W-1:0]   addr;  // Aligned to 8 bytes
    logic [`STQ_DATA_W-1:0]   data;  // Lane-replicated store data
    logic [`STQ_DATA_W/8-1:0] be;    // Byte enable
  } wr_req_t;

  // Load lookup into the store queue
  typedef struct packed {
    logic                     valid;
    logic [`STQ_ADDR_W-1:0]   addr;  // Double-word address, low bits ignored
    logic [`STQ_DATA_W/8-1:0] mask;  // Bytes the load reads
  } fwd_query_t;

  // Forwarded bytes back to the load
  typedef struct packed {
    logic                     hit;
    logic [`STQ_DATA_W/8-1:0] mask;  // Overlap of load and store bytes
    logic [`STQ_DATA_W-1:0]   data;
  } fwd_result_t;

endpackage

// File: logic/stq_pkg.sv
`include "stq_macros.svh"

package stq_pkg;

  // Life of one queue entry
  typedef enum logic [1:0] {
    FREE        = 2'd0,
    WAIT_COMMIT = 2'd1,  // Allocated, searchable
    COMMITTED   = 2'd2,  // Waiting for the drain
    DRAINING    = 2'd3   // Write in flight to the cache
  } state_e;

  // Store as it arrives from the pipeline
  typedef struct packed {
    logic [`STQ_ADDR_W-1:0] addr;
    mem_pkg::size_e         size;
    logic [`STQ_DATA_W-1:0] data;  // Value in the low bits
  } st_req_t;

  // Formatted queue entry
  typedef struct packed {
    state_e           state;
    mem_pkg::wr_req_t req;
  } entry_t;

endpackage

// File: logic/stq_alloc.sv
`include "stq_macros.svh"

module stq_alloc (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_st_valid,
  output logic             o_st_ready,
  input  stq_pkg::st_req_t i_st,
  input  logic             i_full,
  output logic             o_push,
  output stq_pkg::entry_t  o_entry
);

  logic                     r_valid;
  stq_pkg::st_req_t         r_st;
  logic [2:0]               w_off;
  logic [`STQ_DATA_W/8-1:0] w_be_base;
  logic [`STQ_DATA_W-1:0]   w_data;

  assign o_push     = r_valid & ~i_full;
  assign o_st_ready = ~r_valid | ~i_full;  // Empty, or draining into the array now

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else if (o_st_ready) begin
      r_valid <= i_st_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_st_valid && o_st_ready) begin
      r_st <= i_st;
    end
  end

  // ====================================================================
  // Lane replication and byte enable
  // ====================================================================
  always_comb begin
    case (r_st.size)
      mem_pkg::SIZE_B: begin
        w_off     = r_st.addr[2:0];
        w_be_base = 8'h01;
        w_data    = {(`STQ_DATA_W/8){r_st.data[7:0]}};
      end
      mem_pkg::SIZE_H: begin
        w_off     = {r_st.addr[2:1], 1'b0};
        w_be_base = 8'h03;
        w_data    = {(`STQ_DATA_W/16){r_st.data[15:0]}};
      end
      mem_pkg::SIZE_W: begin
        w_off     = {r_st.addr[2], 2'b00};
        w_be_base = 8'h0f;
        w_data    = {(`STQ_DATA_W/32){r_st.data[31:0]}};
      end
      default: begin  // Double word
        w_off     = 3'd0;
        w_be_base = 8'hff;
        w_data    = r_st.data;
      end
    endcase
  end

  assign o_entry.state    = stq_pkg::WAIT_COMMIT;
  assign o_entry.req.addr = {r_st.addr[`STQ_ADDR_W-1:3], 3'b000};
  assign o_entry.req.data = w_data;
  assign o_entry.req.be   = w_be_base << w_off;

endmodule

// File: logic/stq_entry_array.sv
`include "stq_macros.svh"

module stq_entry_array (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_push,
  input  stq_pkg::entry_t      i_entry,
  output logic                 o_full,
  input  logic                 i_commit,
  output stq_pkg::entry_t      o_head,
  input  logic                 i_take,
  input  logic                 i_free,
  input  mem_pkg::fwd_query_t  i_fwd,
  output mem_pkg::fwd_result_t o_fwd
);

  localparam int PTR_W = $clog2(`STQ_DEPTH);

  stq_pkg::state_e  r_state [`STQ_DEPTH];
  mem_pkg::wr_req_t r_req   [`STQ_DEPTH];  // Payload only

  logic [PTR_W-1:0] r_head;
  logic [PTR_W-1:0] r_tail;
  logic [PTR_W-1:0] r_cmt;   // Oldest entry not yet committed
  logic [PTR_W:0]   r_count;

  assign o_full       = (r_count == (PTR_W + 1)'(`STQ_DEPTH));
  assign o_head.state = r_state[r_head];
  assign o_head.req   = r_req[r_head];

  // ====================================================================
  // Pointers and entry states
  // ====================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;
      r_cmt   <= '0;
      r_count <= '0;
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        r_state[i] <= stq_pkg::FREE;
      end
    end else begin
      if (i_push) begin
        r_state[r_tail] <= i_entry.state;
        r_tail          <= r_tail + 1'b1;
      end
      if (i_commit) begin
        r_state[r_cmt] <= stq_pkg::COMMITTED;
        r_cmt          <= r_cmt + 1'b1;
      end
      if (i_take) begin
        r_state[r_head] <= stq_pkg::DRAINING;
      end
      if (i_free) begin  // Write accepted by the cache
        r_state[r_head] <= stq_pkg::FREE;
        r_head          <= r_head + 1'b1;
      end
      case ({i_push, i_free})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_req[r_tail] <= i_entry.req;
    end
  end

  // ====================================================================
  // Forwarding search
  // ====================================================================
  // Walk from head to tail so the last match is the youngest
  always_comb begin
    logic [PTR_W-1:0] idx;
    o_fwd = '0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      idx = r_head + PTR_W'(i);
      if (i_fwd.valid && r_state[idx] != stq_pkg::FREE &&
          r_req[idx].addr[`STQ_ADDR_W-1:3] == i_fwd.addr[`STQ_ADDR_W-1:3] &&
          |(r_req[idx].be & i_fwd.mask)) begin
        o_fwd.hit  = 1'b1;
        o_fwd.mask = r_req[idx].be & i_fwd.mask;
        o_fwd.data = r_req[idx].data;
      end
    end
  end

  // Alloc must hold its store while the array is full
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_push |-> !o_full);

  a_commit_waiting: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit |-> r_state[r_cmt] == stq_pkg::WAIT_COMMIT);

  // Drain frees only what it took earlier
  a_free_draining: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_free |-> r_state[r_head] == stq_pkg::DRAINING);

endmodule

// File: logic/stq_store_drain.sv
module stq_store_drain (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  stq_pkg::entry_t  i_head,
  output logic             o_take,
  output logic             o_free,
  output logic             o_wr_valid,
  input  logic             i_wr_ready,
  output mem_pkg::wr_req_t o_wr
);

  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1  // Request on the cache port
  } drain_state_e;

  drain_state_e     r_state;
  mem_pkg::wr_req_t r_wr;

  // ====================================================================
  // Head pickup and cache handshake
  // ====================================================================
  assign o_take     = (r_state == IDLE) && (i_head.state == stq_pkg::COMMITTED);
  assign o_wr_valid = (r_state == BUSY);
  assign o_free     = (r_state == BUSY) && i_wr_ready;
  assign o_wr       = r_wr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
    end else begin
      case (r_state)
        IDLE: begin
          if (o_take) begin
            r_state <= BUSY;
          end
        end
        BUSY: begin
          if (i_wr_ready) begin  // Accepted, entry freed this edge
            r_state <= IDLE;
          end
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  // Latch the head so the array may move on
  always_ff @(posedge i_clk) begin
    if (o_take) begin
      r_wr <= i_head.req;
    end
  end

  // Held request under back-pressure
  a_wr_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_wr_valid && !i_wr_ready |=> o_wr_valid && $stable(o_wr));

endmodule

// File: logic/stq_top.sv
module stq_top (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_st_valid,
  output logic                 o_st_ready,
  input  stq_pkg::st_req_t     i_st,
  input  logic                 i_commit,
  input  mem_pkg::fwd_query_t  i_fwd,
  output mem_pkg::fwd_result_t o_fwd,
  output logic                 o_wr_valid,
  input  logic                 i_wr_ready,
  output mem_pkg::wr_req_t     o_wr
);

  logic            w_full;
  logic            w_push;
  stq_pkg::entry_t w_entry;
  stq_pkg::entry_t w_head;  // Oldest entry, seen by the drain
  logic            w_take;
  logic            w_free;

  stq_alloc u_alloc (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_st_valid (i_st_valid),
    .o_st_ready (o_st_ready),
    .i_st       (i_st),
    .i_full     (w_full),
    .o_push     (w_push),
    .o_entry    (w_entry)
  );

  stq_entry_array u_entry_array (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_push (w_push), .i_entry (w_entry), .o_full (w_full),
    .i_commit (i_commit), .o_head (w_head),
    .i_take (w_take), .i_free (w_free),
    .i_fwd (i_fwd), .o_fwd (o_fwd)
  );

  stq_store_drain u_store_drain (
    .i_clk (i_clk), .i_reset_n (i_reset_n), .i_head (w_head),
    .o_take (w_take), .o_free (w_free),
    .o_wr_valid (o_wr_valid), .i_wr_ready (i_wr_ready), .o_wr (o_wr)
  );

endmodule

// File: testbench/tb_stq_model.svh
`ifndef TB_STQ_MODEL_SVH
`define TB_STQ_MODEL_SVH

// Stores accepted and not yet written to the cache, oldest first
mem_pkg::wr_req_t model_q[$];
logic             model_cmt[$];
int               model_stamp[$];  // Cycle count at acceptance

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Aligned double word, raw low bytes on every lane, size mask at the offset
function automatic mem_pkg::wr_req_t format_store(input stq_pkg::st_req_t st);
  mem_pkg::wr_req_t r;
  int               nbytes;
  int               off;
  nbytes = 1 << int'(st.size);
  off    = (int'(st.addr[2:0]) / nbytes) * nbytes;
  r.addr = {st.addr[`STQ_ADDR_W-1:3], 3'b000};
  for (int b = 0; b < 8; b++) begin
    r.data[b*8 +: 8] = st.data[(b % nbytes)*8 +: 8];
    r.be[b]          = (b >= off) && (b < off + nbytes);
  end
  return r;
endfunction

// Later matches overwrite earlier ones, so the youngest store wins
function automatic mem_pkg::fwd_result_t model_forward(input mem_pkg::fwd_query_t q);
  mem_pkg::fwd_result_t r;
  r = '0;
  foreach (model_q[i]) begin
    if (q.valid && model_q[i].addr == {q.addr[`STQ_ADDR_W-1:3], 3'b000} &&
        (model_q[i].be & q.mask) != 8'h00) begin
      r.hit  = 1'b1;
      r.mask = model_q[i].be & q.mask;
      r.data = model_q[i].data;
    end
  end
  return r;
endfunction

function automatic int oldest_open();  // -1 when all are committed
  foreach (model_cmt[i]) begin
    if (!model_cmt[i]) return i;
  end
  return -1;
endfunction

`endif

// File: testbench/tb_stq.sv
`include "stq_macros.svh"

module tb_stq;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CYCLE_LIMIT = 20000;  // About 1500 cycles of traffic plus drains

  logic                 i_clk;
  logic                 i_reset_n;
  logic                 i_st_valid;
  logic                 o_st_ready;
  stq_pkg::st_req_t     i_st;
  logic                 i_commit;
  mem_pkg::fwd_query_t  i_fwd;
  mem_pkg::fwd_result_t o_fwd;
  logic                 o_wr_valid;
  logic                 i_wr_ready;
  mem_pkg::wr_req_t     o_wr;

  int               cyc = 0;
  int               errors = 0;
  int               n_tests = 0;
  int               n_failed = 0;
  int               n_accept = 0;
  int               n_commit = 0;
  int               n_write = 0;
  logic [31:0]      seed = 32'd49014;
  logic             held_valid = 1'b0;  // Request waited at the last edge
  mem_pkg::wr_req_t held_wr;

  `include "tb_stq_model.svh"

  stq_top u_stq_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  always @(posedge i_clk) cyc <= cyc + 1;

  initial begin
    wait (cyc >= CYCLE_LIMIT);
    $display("Timeout: run stopped at cycle %0d", cyc);
    $display("Done: errors found");
    $finish;
  end

  function automatic logic [31:0] next_random();
    seed = xorshift32(seed);
    return seed;
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    errors++;
    $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
  endtask

  // Oldest open store surely sits in the array, not in the input register
  function automatic logic can_commit();
    int k;
    k = oldest_open();
    return k >= 0 && k <= 6 && cyc - model_stamp[k] >= 2;
  endfunction

  task automatic random_store(input logic [31:0] addr_mask);
    logic [31:0] r;
    r         = next_random();
    i_st.addr = r & addr_mask;
    i_st.size = mem_pkg::size_e'(r[9:8]);
    i_st.data = {next_random(), next_random()};
  endtask

  // ====================================================================
  // Sample 1 ns after the drive, then move on to the next falling edge
  // ====================================================================
  task automatic step_cycle();
    mem_pkg::fwd_result_t exp_fwd;
    int                   k;
    #1;
    exp_fwd = model_forward(i_fwd);
    if (i_fwd.valid && o_fwd.hit !== exp_fwd.hit)
      report_mismatch("o_fwd.hit", o_fwd.hit, exp_fwd.hit);
    if (exp_fwd.hit && o_fwd.mask !== exp_fwd.mask)
      report_mismatch("o_fwd.mask", o_fwd.mask, exp_fwd.mask);
    if (exp_fwd.hit && o_fwd.data !== exp_fwd.data)
      report_mismatch("o_fwd.data", o_fwd.data, exp_fwd.data);
    if (held_valid && o_wr_valid !== 1'b1)
      report_mismatch("o_wr_valid", o_wr_valid, 1'b1);
    if (held_valid && o_wr !== held_wr)
      report_mismatch("o_wr (held)", o_wr, held_wr);
    if (o_wr_valid && i_wr_ready) begin
      n_write++;
      if (model_q.size() == 0 || !model_cmt[0]) begin
        errors++;
        $display("[FAIL] t=%0t cache write with no committed store waiting", $time);
      end else begin
        if (o_wr !== model_q[0]) report_mismatch("o_wr", o_wr, model_q[0]);
        void'(model_q.pop_front());
        void'(model_cmt.pop_front());
        void'(model_stamp.pop_front());
      end
    end
    held_valid = o_wr_valid && !i_wr_ready;
    held_wr    = o_wr;
    k = oldest_open();
    if (i_commit && k >= 0) begin  // Commit marks the oldest open store
      model_cmt[k] = 1'b1;
      n_commit++;
    end
    if (i_st_valid && o_st_ready) begin
      model_q.push_back(format_store(i_st));
      model_cmt.push_back(1'b0);
      model_stamp.push_back(cyc);
      n_accept++;
    end
    @(negedge i_clk);
  endtask

  task automatic drive_random(input int st_pct, input int cmt_pct, input int rdy_pct);
    i_st_valid = (next_random() % 100) < st_pct;
    random_store(32'h3f);
    i_commit   = can_commit() && (next_random() % 100) < cmt_pct;
    i_wr_ready = (next_random() % 100) < rdy_pct;
    i_fwd      = '0;
  endtask

  task automatic drain_queue();
    i_st_valid = 1'b0;
    i_fwd      = '0;
    while (model_q.size() != 0) begin
      i_commit   = can_commit();
      i_wr_ready = next_random() % 4 != 0;
      step_cycle();
    end
    i_commit = 1'b0;
  endtask

  task automatic close_test(input string name, input int err_start);
    n_tests++;
    if (errors == err_start) begin
      $display("Test %0d %s: ok", n_tests, name);
    end else begin
      n_failed++;
      $display("Test %0d %s: %0d errors", n_tests, name, errors - err_start);
    end
  endtask

  initial begin
    int          err_start;
    int          k;
    logic [31:0] old_addr[$];
    i_reset_n  = 1'b0;
    i_st_valid = 1'b0;
    i_st       = '0;
    i_commit   = 1'b0;
    i_fwd      = '0;
    i_wr_ready = 1'b0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    err_start = errors;
    if (o_wr_valid !== 1'b0) report_mismatch("o_wr_valid", o_wr_valid, 1'b0);
    if (o_st_ready !== 1'b1) report_mismatch("o_st_ready", o_st_ready, 1'b1);
    i_fwd = '{valid: 1'b1, addr: 32'h0, mask: 8'hff};
    step_cycle();
    close_test("reset", err_start);

    err_start = errors;
    n_commit  = 0;
    n_write   = 0;
    repeat (600) begin
      drive_random(60, 40, 100);
      step_cycle();
    end
    drain_queue();
    if (n_write != n_commit) report_mismatch("write count", n_write, n_commit);
    close_test("write order", err_start);

    err_start = errors;
    n_accept  = 0;
    n_write   = 0;
    repeat (600) begin
      drive_random(60, 40, 40);
      step_cycle();
    end
    drain_queue();
    if (n_write != n_accept) report_mismatch("write count", n_write, n_accept);
    close_test("back-pressure", err_start);

    // ==================================================================
    // Full queue, then forwarding
    // ==================================================================
    err_start  = errors;
    n_accept   = 0;
    n_write    = 0;
    i_wr_ready = 1'b1;
    i_st_valid = 1'b1;
    repeat (16) begin
      if (n_accept == 9 && o_st_ready !== 1'b0)
        report_mismatch("o_st_ready", o_st_ready, 1'b0);
      random_store(32'h3f);
      step_cycle();
    end
    if (n_accept != 9) report_mismatch("accepted stores", n_accept, 9);
    i_st_valid = 1'b0;
    i_commit   = can_commit();
    step_cycle();
    i_commit = 1'b0;
    while (!o_st_ready) step_cycle();
    if (n_write != 1) report_mismatch("writes before o_st_ready", n_write, 1);
    drain_queue();
    close_test("full queue", err_start);

    err_start  = errors;
    n_accept   = 0;
    i_st_valid = 1'b1;
    while (n_accept < 6) begin
      random_store(32'h1f);  // Four double words, so stores overlap
      step_cycle();
    end
    i_st_valid = 1'b0;
    repeat (2) step_cycle();
    repeat (40) begin
      k = next_random() % model_q.size();
      i_fwd.valid = 1'b1;
      i_fwd.addr  = model_q[k].addr | (next_random() & 32'h7);
      i_fwd.mask  = 8'(next_random()) | model_q[k].be;
      step_cycle();
    end
    close_test("forward hit", err_start);

    err_start = errors;
    repeat (20) begin
      k = next_random() % model_q.size();
      i_fwd.addr = model_q[k].addr;
      i_fwd.mask = 8'h00;
      foreach (model_q[j]) begin
        if (model_q[j].addr == model_q[k].addr) i_fwd.mask = i_fwd.mask | model_q[j].be;
      end
      i_fwd.mask  = ~i_fwd.mask;  // Only bytes no store touches
      i_fwd.valid = i_fwd.mask != 8'h00;
      old_addr.push_back(model_q[k].addr);
      step_cycle();
      i_fwd = '{valid: 1'b1, addr: 32'h100 | (next_random() & 32'hff), mask: 8'hff};
      step_cycle();
    end
    drain_queue();
    foreach (old_addr[j]) begin
      i_fwd = '{valid: 1'b1, addr: old_addr[j], mask: 8'hff};
      step_cycle();
    end
    close_test("forward miss", err_start);

    $display("Tests: %0d run, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+logic
+incdir+testbench
logic/mem_pkg.sv
logic/stq_pkg.sv
logic/stq_alloc.sv
logic/stq_entry_array.sv
logic/stq_store_drain.sv
logic/stq_top.sv
testbench/tb_stq.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
LINTFLAGS := --lint-only --timing -Wall --timescale 1ns/100ps
TOP       := tb_stq
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Done: no errors
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
